/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/rnd_align.sv */
////////////////////////////////////////
// stage 1, one right shifter for both
// directions, left shift limited to 15
////////////////////////////////////////

`default_nettype none

module rnd_align
  import rnd_fmt_pkg::*;
  import rnd_pipe_pkg::*;
(
  input  wire cpu_clk,
  input  wire adv_i,
  input  s0_t s0_i,
  output s1_t s1_o
);

  logic [WORK_W-1:0] shifted;
  logic [WORK_W-1:0] shifted_rev;
  logic [WORK_W-1:0] aligned;
  logic [WORK_W-1:0] rmask;
  logic [1:0]        lbits;
  logic              sticky_r;
  logic              sticky_l;
  logic              sticky;

  ////////////////////////////////////////
  // shift
  ////////////////////////////////////////

  assign shifted     = s0_i.fract >> s0_i.sh;
  assign shifted_rev = {<<{shifted}};
  // undo reversal for left shift
  assign aligned     = s0_i.is_shr ? shifted : shifted_rev;

  ////////////////////////////////////////
  // sticky
  ////////////////////////////////////////

  // right: bits [shr+1:0] of the unreversed word
  assign rmask    = ({{(WORK_W-1){1'b0}}, 1'b1} << (s0_i.shr + 7'd2)) - 1'b1;
  assign sticky_r = |(s0_i.fract & rmask);

  // left: original two lsbs sit at the reversed top
  assign lbits = {s0_i.fract[WORK_W-2], s0_i.fract[WORK_W-1]};

  always_comb begin
    case (s0_i.shl)
      '0:      sticky_l = |lbits;
      'd1:     sticky_l = lbits[0];
      default: sticky_l = 1'b0;
    endcase
  end

  assign sticky = s0_i.is_shr ? sticky_r : sticky_l;

  always_ff @(posedge cpu_clk) begin
    if (adv_i) begin
      s1_o.sign    <= s0_i.sign;
      s1_o.exp     <= s0_i.exp;
      s1_o.fract   <= aligned[WORK_W-1:3];
      // round bit then sticky
      s1_o.rs      <= {aligned[2], sticky};
      s1_o.spec    <= s0_i.spec;
      s1_o.f2i     <= s0_i.f2i;
      s1_o.f2i_ovf <= s0_i.f2i_ovf;
    end
  end

endmodule

`default_nettype wire

/* design/rnd_cfg_regs.sv */
////////////////////////////////////////
// rounding control register
// new values apply on the next cycle
////////////////////////////////////////

`default_nettype none

module rnd_cfg_regs
  import rnd_pipe_pkg::*;
(
  input  wire        cpu_clk,
  input  wire        arst_n_i,
  input  wire        cfg_we_i,
  input  rnd_mode_e  cfg_mode_i,
  input  rnd_flags_t cfg_mask_i,
  input  wire        cfg_exc_en_i,
  output rnd_mode_e  mode_o,
  output rnd_flags_t mask_o,
  output logic       exc_en_o
);

  // defaults: nearest even, all flags visible, no traps
  always_ff @(posedge cpu_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mode_o   <= RM_NEAREST;
      mask_o   <= '1;
      exc_en_o <= 1'b0;
    end else if (cfg_we_i) begin
      mode_o   <= cfg_mode_i;
      mask_o   <= cfg_mask_i;
      exc_en_o <= cfg_exc_en_i;
    end
  end

endmodule

`default_nettype wire

/* design/rnd_fmt_pkg.sv */
////////////////////////////////////////
// single precision only, internal
// exponent is biased with two spare
// bits to catch overflow after rounding
////////////////////////////////////////

`default_nettype none

package rnd_fmt_pkg;

  // widths
  localparam int EXP_W   = 10;
  localparam int FRACT_W = 27;
  localparam int INT_W   = 32;
  localparam int WORK_W  = INT_W + 3;
  localparam int SHIFT_W = 6;

  // largest finite biased exponent
  localparam logic [EXP_W-1:0] EXP_MAX = 10'd254;

  // special magnitudes, sign bit added on use
  localparam logic [30:0] INF_S  = 31'h7f80_0000;
  localparam logic [30:0] QNAN_S = 31'h7fc0_0000;
  localparam logic [30:0] SNAN_S = 31'h7fbf_ffff;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] fract;
  } rnd_flt_t;

  // result word, float or integer view
  typedef union packed {
    rnd_flt_t                 flt;
    logic signed [INT_W-1:0] ival;
  } rnd_res_u;

endpackage

`default_nettype wire

/* design/rnd_pipe_ctrl.sv */
////////////////////////////////////////
// stage ready, miss and valid state
// req_i must be the OR of producer rdys
////////////////////////////////////////

`default_nettype none

module rnd_pipe_ctrl (
  input  wire  cpu_clk,
  input  wire  arst_n_i,
  input  wire  flush_i,
  input  wire  req_i,
  input  wire  padv_wb_i,
  input  wire  grant_wb_i,
  output logic s0_adv_o,
  output logic s1_adv_o,
  output logic s2_adv_o,
  output logic miss_o,
  output logic valid_o
);

  logic s0_rdy, s1_rdy, s2_rdy;
  logic s0_busy, s1_busy, s2_busy;
  logic wb_take;

  // busy ripples back from a pending miss
  assign s2_busy = s2_rdy & miss_o;
  assign s1_busy = s1_rdy & s2_busy;
  assign s0_busy = s0_rdy & s1_busy;

  assign s0_adv_o = req_i & ~s0_busy;
  assign s1_adv_o = s0_rdy & ~s1_busy;
  assign s2_adv_o = s1_rdy & ~s2_busy;

  assign wb_take = padv_wb_i & grant_wb_i;

  always_ff @(posedge cpu_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s0_rdy  <= 1'b0;
      s1_rdy  <= 1'b0;
      s2_rdy  <= 1'b0;
      miss_o  <= 1'b0;
      valid_o <= 1'b0;
    end else if (flush_i) begin
      s0_rdy  <= 1'b0;
      s1_rdy  <= 1'b0;
      s2_rdy  <= 1'b0;
      miss_o  <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      // stage 0 and 1 ready
      if (s0_adv_o) s0_rdy <= 1'b1;
      else if (s1_adv_o) s0_rdy <= 1'b0;
      if (s1_adv_o) s1_rdy <= 1'b1;
      else if (s2_adv_o) s1_rdy <= 1'b0;
      // stage 2 holds only while missed
      if (s2_adv_o) s2_rdy <= 1'b1;
      else if (!miss_o) s2_rdy <= 1'b0;
      // miss: set when a result sits untaken
      if (wb_take) miss_o <= 1'b0;
      else if (!miss_o) miss_o <= s2_rdy;
      // a take during miss may expose the next result
      if (s2_adv_o) valid_o <= 1'b1;
      else if (wb_take) valid_o <= miss_o ? s2_rdy : 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/rnd_pipe_pkg.sv */
////////////////////////////////////////
// producer, stage and flag layouts
// flag order follows the FPCSR bits
////////////////////////////////////////

`default_nettype none

package rnd_pipe_pkg;
  import rnd_fmt_pkg::*;

  localparam int FLAG_W = 8;

  typedef enum logic [1:0] {
    RM_NEAREST = 2'd0,
    RM_ZERO    = 2'd1,
    RM_UP      = 2'd2,
    RM_DOWN    = 2'd3
  } rnd_mode_e;

  // msb first: inf inv ine zer qnan snan unf ovf
  typedef struct packed {
    logic inf;
    logic inv;
    logic ine;
    logic zer;
    logic qnan;
    logic snan;
    logic unf;
    logic ovf;
  } rnd_flags_t;

  // add/sub style producer
  typedef struct packed {
    logic               sign;
    logic               sub_zero;
    logic               shr;
    logic [SHIFT_W-1:0] shl;
    logic [EXP_W-1:0]   exp_shr;
    logic [EXP_W-1:0]   exp_shl;
    logic [EXP_W-1:0]   exp_sh0;
    logic [FRACT_W-1:0] fract;
  } fp_src_t;

  // float to integer producer
  typedef struct packed {
    logic               sign;
    logic [23:0]        int24;
    logic [SHIFT_W-1:0] shr;
    logic [3:0]         shl;
    logic               ovf;
  } f2i_src_t;

  // order buffer specials
  typedef struct packed {
    logic inv;
    logic inf;
    logic snan;
    logic qnan;
    logic anan_sign;
  } spec_t;

  typedef struct packed {
    logic               sign;
    logic               is_shr;
    logic [SHIFT_W-1:0] shr;
    logic [SHIFT_W-1:0] shl;
    logic [SHIFT_W-1:0] sh;
    logic [EXP_W-1:0]   exp;
    logic [WORK_W-1:0]  fract;
    spec_t              spec;
    logic               f2i;
    logic               f2i_ovf;
  } s0_t;

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [INT_W-1:0] fract;
    logic [1:0]       rs;
    spec_t            spec;
    logic             f2i;
    logic             f2i_ovf;
  } s1_t;

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [INT_W-1:0] fract;
    logic             lost;
    spec_t            spec;
    logic             f2i;
    logic             f2i_ovf;
  } s2_t;

endpackage

`default_nettype wire

/* design/rnd_round_format.sv */
////////////////////////////////////////
// stage 2 rounding register and stage 3
// formatting, which is combinational
// result and flags valid while s2 holds
////////////////////////////////////////

`default_nettype none

module rnd_round_format
  import rnd_fmt_pkg::*;
  import rnd_pipe_pkg::*;
(
  input  wire        cpu_clk,
  input  wire        adv_i,
  input  s1_t        s1_i,
  input  rnd_mode_e  mode_i,
  input  rnd_flags_t mask_i,
  output rnd_res_u   res_o,
  output rnd_flags_t flags_o
);

  s2_t              s2_q;
  logic             g, r, s, lost, rnd_up;
  logic             fxx_shr, fxx_dn, fxx_ovf;
  logic [EXP_W-1:0] fxx_exp;
  logic [23:0]      fxx_fract;
  logic             ixx_inv, ixx_zero;
  logic [INT_W-1:0] ixx_val, ixx_max;
  rnd_flags_t       raw;

  ////////////////////////////////////////
  // stage 2: rounding
  ////////////////////////////////////////

  // guard is the result lsb
  assign g    = s1_i.fract[0];
  assign r    = s1_i.rs[1];
  assign s    = s1_i.rs[0];
  assign lost = r | s;

  always_comb begin
    case (mode_i)
      // ties go to even
      RM_NEAREST: rnd_up = (r & s) | (g & r & ~s);
      RM_UP:      rnd_up = ~s1_i.sign & lost;
      RM_DOWN:    rnd_up = s1_i.sign & lost;
      default:    rnd_up = 1'b0;
    endcase
  end

  always_ff @(posedge cpu_clk) begin
    if (adv_i) begin
      s2_q.sign    <= s1_i.sign;
      s2_q.exp     <= s1_i.exp;
      s2_q.fract   <= s1_i.fract + INT_W'(rnd_up);
      s2_q.lost    <= lost;
      s2_q.spec    <= s1_i.spec;
      s2_q.f2i     <= s1_i.f2i;
      s2_q.f2i_ovf <= s1_i.f2i_ovf;
    end
  end

  ////////////////////////////////////////
  // stage 3: float and integer results
  ////////////////////////////////////////

  // carry out of rounding renormalizes
  assign fxx_shr   = s2_q.fract[24];
  assign fxx_exp   = s2_q.exp + EXP_W'(fxx_shr);
  assign fxx_fract = fxx_shr ? s2_q.fract[24:1] : s2_q.fract[23:0];
  // no hidden bit means denormal or zero
  assign fxx_dn    = ~fxx_fract[23];
  assign fxx_ovf   = (fxx_exp > EXP_MAX) | s2_q.spec.inf;

  // positive rounding into bit 31 is out of range
  assign ixx_inv  = (~s2_q.sign & s2_q.fract[INT_W-1]) | s2_q.f2i_ovf;
  assign ixx_val  = (s2_q.fract ^ {INT_W{s2_q.sign}}) + INT_W'(s2_q.sign);
  assign ixx_zero = ~ixx_inv & ~(|s2_q.fract);
  assign ixx_max  = {1'b0, {(INT_W-1){1'b1}}} ^ {INT_W{s2_q.sign}};

  // fixed priority, f2i first
  always_comb begin
    raw      = '0;
    raw.inv  = s2_q.spec.inv | s2_q.spec.snan | (s2_q.f2i & ixx_inv);
    raw.qnan = s2_q.spec.qnan;
    raw.snan = s2_q.spec.inv | (s2_q.spec.snan & s2_q.f2i);
    if (s2_q.f2i) begin
      raw.ine    = s2_q.lost;
      raw.zer    = ixx_zero;
      res_o.ival = ixx_inv ? ixx_max : ixx_val;
    end else if (s2_q.spec.snan | s2_q.spec.qnan) begin
      res_o.flt = {s2_q.spec.anan_sign, QNAN_S};
    end else if (s2_q.spec.inv) begin
      res_o.flt = {s2_q.sign, SNAN_S};
    end else if (fxx_ovf) begin
      // infinite operand is exact, no ovf
      raw.ine   = s2_q.lost | ~s2_q.spec.inf;
      raw.ovf   = ~s2_q.spec.inf;
      raw.inf   = 1'b1;
      res_o.flt = {s2_q.sign, INF_S};
    end else if (fxx_dn) begin
      raw.ine   = s2_q.lost;
      raw.unf   = s2_q.lost;
      raw.zer   = ~(|fxx_fract);
      res_o.flt = {s2_q.sign, 8'd0, fxx_fract[22:0]};
    end else begin
      raw.ine   = s2_q.lost;
      res_o.flt = {s2_q.sign, fxx_exp[7:0], fxx_fract[22:0]};
    end
  end

  assign flags_o = raw & mask_i;

endmodule

`default_nettype wire

/* design/rnd_src_mux.sv */
////////////////////////////////////////
// stage 0, one producer rdy at a time
// fraction stored reversed on left shift
////////////////////////////////////////

`default_nettype none

module rnd_src_mux
  import rnd_fmt_pkg::*;
  import rnd_pipe_pkg::*;
(
  input  wire       cpu_clk,
  input  wire       adv_i,
  input  wire       fp_rdy_i,
  input  fp_src_t   fp_src_i,
  input  wire       f2i_rdy_i,
  input  f2i_src_t  f2i_src_i,
  input  spec_t     spec_i,
  input  rnd_mode_e mode_i,
  output s0_t       s0_o
);

  s0_t               s0_d;
  logic              is_shl;
  logic [WORK_W-1:0] fract;
  logic [WORK_W-1:0] fract_rev;

  assign fract_rev = {<<{fract}};

  always_comb begin
    s0_d = '0;
    fract = '0;
    if (fp_rdy_i) begin
      // exact zero of a subtraction is -0 only toward minus infinity
      s0_d.sign = fp_src_i.sub_zero ? (mode_i == RM_DOWN) : fp_src_i.sign;
      s0_d.shr  = {{(SHIFT_W-1){1'b0}}, fp_src_i.shr};
      s0_d.shl  = fp_src_i.shl;
      // carry lands on bit 27, spare lsb
      fract = {{(WORK_W-FRACT_W-1){1'b0}}, fp_src_i.fract, 1'b0};
    end else if (f2i_rdy_i) begin
      s0_d.sign = f2i_src_i.sign;
      s0_d.shr  = f2i_src_i.shr;
      s0_d.shl  = {{(SHIFT_W-4){1'b0}}, f2i_src_i.shl};
      fract = {{(WORK_W-27){1'b0}}, f2i_src_i.int24, 3'd0};
    end
    s0_d.is_shr = |s0_d.shr;
    is_shl = |s0_d.shl;
    // right over left over none
    s0_d.sh = s0_d.is_shr ? s0_d.shr : (is_shl ? s0_d.shl : '0);
    // f2i carries no exponent
    if (fp_rdy_i) begin
      s0_d.exp = s0_d.is_shr ? fp_src_i.exp_shr :
                 is_shl      ? fp_src_i.exp_shl : fp_src_i.exp_sh0;
    end
    s0_d.fract   = s0_d.is_shr ? fract : fract_rev;
    s0_d.spec    = spec_i;
    s0_d.f2i     = f2i_rdy_i;
    s0_d.f2i_ovf = f2i_src_i.ovf;
  end

  always_ff @(posedge cpu_clk) begin
    if (adv_i) s0_o <= s0_d;
  end

endmodule

`default_nettype wire

/* design/rnd_top.sv */
////////////////////////////////////////
// rounding unit, single precision
// at most one producer rdy per cycle
////////////////////////////////////////

`default_nettype none

module rnd_top
  import rnd_fmt_pkg::*;
  import rnd_pipe_pkg::*;
(
  input  wire        cpu_clk,
  input  wire        arst_n_i,
  input  wire        flush_i,
  // producers
  input  wire        fp_rdy_i,
  input  fp_src_t    fp_src_i,
  input  wire        f2i_rdy_i,
  input  f2i_src_t   f2i_src_i,
  input  spec_t      spec_i,
  output logic       fp_taking_o,
  output logic       f2i_taking_o,
  // configuration
  input  wire        cfg_we_i,
  input  rnd_mode_e  cfg_mode_i,
  input  rnd_flags_t cfg_mask_i,
  input  wire        cfg_exc_en_i,
  // write-back
  input  wire        padv_wb_i,
  input  wire        grant_wb_i,
  output logic       valid_o,
  output rnd_res_u   wb_res_o,
  output rnd_flags_t wb_flags_o,
  output logic       wb_fpcsr_we_o,
  output logic       exc_o,
  output logic       wb_except_o
);

  rnd_mode_e  mode;
  rnd_flags_t mask, flags;
  rnd_res_u   res;
  logic       exc_en, miss;
  logic       s0_adv, s1_adv, s2_adv;
  s0_t        s0;
  s1_t        s1;

  // s0 advance already implies stage 0 not busy
  assign fp_taking_o  = fp_rdy_i & s0_adv;
  assign f2i_taking_o = f2i_rdy_i & s0_adv;

  rnd_cfg_regs cfg0 (
    .cpu_clk(cpu_clk), .arst_n_i(arst_n_i), .cfg_we_i(cfg_we_i),
    .cfg_mode_i(cfg_mode_i), .cfg_mask_i(cfg_mask_i), .cfg_exc_en_i(cfg_exc_en_i),
    .mode_o(mode), .mask_o(mask), .exc_en_o(exc_en)
  );

  rnd_pipe_ctrl ctrl0 (
    .cpu_clk(cpu_clk), .arst_n_i(arst_n_i), .flush_i(flush_i),
    .req_i(fp_rdy_i | f2i_rdy_i), .padv_wb_i(padv_wb_i), .grant_wb_i(grant_wb_i),
    .s0_adv_o(s0_adv), .s1_adv_o(s1_adv), .s2_adv_o(s2_adv),
    .miss_o(miss), .valid_o(valid_o)
  );

  rnd_src_mux src0 (
    .cpu_clk(cpu_clk), .adv_i(s0_adv),
    .fp_rdy_i(fp_rdy_i), .fp_src_i(fp_src_i),
    .f2i_rdy_i(f2i_rdy_i), .f2i_src_i(f2i_src_i),
    .spec_i(spec_i), .mode_i(mode), .s0_o(s0)
  );

  rnd_align align0 (
    .cpu_clk(cpu_clk), .adv_i(s1_adv), .s0_i(s0), .s1_o(s1)
  );

  rnd_round_format fmt0 (
    .cpu_clk(cpu_clk), .adv_i(s2_adv), .s1_i(s1), .mode_i(mode),
    .mask_i(mask), .res_o(res), .flags_o(flags)
  );

  rnd_wb_buffer wb0 (
    .cpu_clk(cpu_clk), .arst_n_i(arst_n_i), .flush_i(flush_i), .miss_i(miss),
    .padv_wb_i(padv_wb_i), .grant_wb_i(grant_wb_i), .exc_en_i(exc_en),
    .res_i(res), .flags_i(flags), .wb_res_o(wb_res_o), .wb_flags_o(wb_flags_o),
    .wb_fpcsr_we_o(wb_fpcsr_we_o), .exc_o(exc_o), .wb_except_o(wb_except_o)
  );

endmodule

`default_nettype wire

/* design/rnd_wb_buffer.sv */
////////////////////////////////////////
// write-back registers and miss copy
// flags only meaningful with fpcsr we
////////////////////////////////////////

`default_nettype none

module rnd_wb_buffer
  import rnd_fmt_pkg::*;
  import rnd_pipe_pkg::*;
(
  input  wire        cpu_clk,
  input  wire        arst_n_i,
  input  wire        flush_i,
  input  wire        miss_i,
  input  wire        padv_wb_i,
  input  wire        grant_wb_i,
  input  wire        exc_en_i,
  input  rnd_res_u   res_i,
  input  rnd_flags_t flags_i,
  output rnd_res_u   wb_res_o,
  output rnd_flags_t wb_flags_o,
  output logic       wb_fpcsr_we_o,
  output logic       exc_o,
  output logic       wb_except_o
);

  rnd_res_u   res_pend, res_m;
  rnd_flags_t flags_pend, flags_m;

  // frozen once a miss is pending
  always_ff @(posedge cpu_clk) begin
    if (!miss_i) begin
      res_pend   <= res_i;
      flags_pend <= flags_i;
    end
  end

  assign res_m   = miss_i ? res_pend : res_i;
  assign flags_m = miss_i ? flags_pend : flags_i;

  assign exc_o = grant_wb_i & exc_en_i & (|flags_m);

  // zero when write-back goes to another unit
  always_ff @(posedge cpu_clk) begin
    if (padv_wb_i) begin
      if (grant_wb_i) begin
        wb_res_o   <= res_m;
        wb_flags_o <= flags_m;
      end else begin
        wb_res_o   <= '0;
        wb_flags_o <= {FLAG_W{1'b0}};
      end
    end
  end

  // single cycle fpcsr update
  always_ff @(posedge cpu_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_fpcsr_we_o <= 1'b0;
      wb_except_o   <= 1'b0;
    end else if (flush_i) begin
      wb_fpcsr_we_o <= 1'b0;
      wb_except_o   <= 1'b0;
    end else begin
      wb_fpcsr_we_o <= padv_wb_i & grant_wb_i;
      if (padv_wb_i) wb_except_o <= exc_o;
    end
  end

endmodule

`default_nettype wire

/* verif/rnd_sva.sv */
////////////////////////////////////////
// control checks bound into rnd_top
// inactive while reset is asserted
////////////////////////////////////////

`default_nettype none

module rnd_sva (
  input wire cpu_clk,
  input wire arst_n_i,
  input wire flush_i,
  input wire fp_taking_o,
  input wire f2i_taking_o,
  input wire valid_o,
  input wire wb_fpcsr_we_o
);

  // fpcsr write is a single cycle pulse
  a_we_pulse: assert property (@(posedge cpu_clk) disable iff (!arst_n_i)
    wb_fpcsr_we_o |=> !wb_fpcsr_we_o)
    else $error("wb_fpcsr_we_o high on two consecutive cycles");

  // only one producer taken per cycle
  a_take_excl: assert property (@(posedge cpu_clk) disable iff (!arst_n_i)
    !(fp_taking_o && f2i_taking_o))
    else $error("both taking outputs high");

  // flush drops any pending result
  a_flush_valid: assert property (@(posedge cpu_clk) disable iff (!arst_n_i)
    flush_i |=> !valid_o)
    else $error("valid_o high after flush");

endmodule

bind rnd_top rnd_sva sva0 (
  .cpu_clk(cpu_clk),
  .arst_n_i(arst_n_i),
  .flush_i(flush_i),
  .fp_taking_o(fp_taking_o),
  .f2i_taking_o(f2i_taking_o),
  .valid_o(valid_o),
  .wb_fpcsr_we_o(wb_fpcsr_we_o)
);

`default_nettype wire

/* verif/tb_clk_gen.sv */
////////////////////////////////////////
// free running clock, period 10
// reset held low for the first 5 edges
////////////////////////////////////////

`default_nettype none

module tb_clk_gen (
  output logic cpu_clk_o,
  output logic arst_n_o
);

  initial begin
    cpu_clk_o = 1'b0;
    arst_n_o  = 1'b0;
    repeat (5) @(posedge cpu_clk_o);
    arst_n_o <= 1'b1;
  end

  always #5 cpu_clk_o = ~cpu_clk_o;

endmodule

`default_nettype wire

/* verif/tb_top.sv */
////////////////////////////////////////
// table driven rounding unit testbench
// each row waits for write-back pulse
// stall cycles get a random 0..2 extra
////////////////////////////////////////

`default_nettype none

module tb_top
  import rnd_fmt_pkg::*;
  import rnd_pipe_pkg::*;
;

  typedef struct packed {
    rnd_mode_e   mode;
    rnd_flags_t  mask;
    logic        exc_en;
    logic        use_f2i;
    fp_src_t     fp;
    f2i_src_t    f2i;
    spec_t       spec;
    logic [3:0]  stall;
    logic [31:0] exp_res;
    rnd_flags_t  exp_flags;
    logic        exp_exc;
  } row_t;

  logic       cpu_clk, arst_n_i, flush_i;
  logic       fp_rdy_i, f2i_rdy_i, fp_taking_o, f2i_taking_o;
  fp_src_t    fp_src_i;
  f2i_src_t   f2i_src_i;
  spec_t      spec_i;
  logic       cfg_we_i, cfg_exc_en_i;
  rnd_mode_e  cfg_mode_i;
  rnd_flags_t cfg_mask_i, wb_flags_o;
  logic       padv_wb_i, grant_wb_i, valid_o;
  rnd_res_u   wb_res_o;
  logic       wb_fpcsr_we_o, exc_o, wb_except_o;

  row_t rows[$];
  int   pass_cnt = 0;
  int   fail_cnt = 0;
  int   cycles = 0;
  int   limit = 100000;

  tb_clk_gen clk0 (.cpu_clk_o(cpu_clk), .arst_n_o(arst_n_i));

  rnd_top dut0 (.*);

  // fraction layout: carry, hidden, 23 bits, then round and sticky
  // unused exponents are poisoned so a wrong pick shows up
  function automatic fp_src_t float_src(input logic sign, input logic sub_zero,
                                        input logic shr, input logic [9:0] exp,
                                        input logic [24:0] mant, input logic [1:0] rs);
    fp_src_t src;
    src          = '0;
    src.sign     = sign;
    src.sub_zero = sub_zero;
    src.shr      = shr;
    src.exp_shr  = shr ? exp : 10'h3ff;
    src.exp_shl  = 10'h3ff;
    src.exp_sh0  = shr ? 10'h3ff : exp;
    src.fract    = {mant, rs};
    return src;
  endfunction

  function automatic f2i_src_t int_src(input logic sign, input logic [23:0] mag,
                                       input logic [5:0] shr, input logic [3:0] shl,
                                       input logic ovf);
    f2i_src_t src;
    src.sign  = sign;
    src.int24 = mag;
    src.shr   = shr;
    src.shl   = shl;
    src.ovf   = ovf;
    return src;
  endfunction

  task automatic add_row(input rnd_mode_e mode, input rnd_flags_t mask, input logic exc_en,
                         input logic use_f2i, input fp_src_t fp, input f2i_src_t f2i,
                         input spec_t spec, input logic [3:0] stall,
                         input logic [31:0] res, input rnd_flags_t flags, input logic exc);
    row_t row;
    row.mode      = mode;
    row.mask      = mask;
    row.exc_en    = exc_en;
    row.use_f2i   = use_f2i;
    row.fp        = fp;
    row.f2i       = f2i;
    row.spec      = spec;
    row.stall     = stall;
    row.exp_res   = res;
    row.exp_flags = flags;
    row.exp_exc   = exc;
    rows.push_back(row);
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic build_table;
    // nearest even: tie up to even, tie stays even, round and sticky
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b0, float_src(0, 0, 0, 10'd127, 25'h0800001, 2'b10),
            '0, '0, 4'd0, 32'h3f80_0002, 8'h20, 1'b0);
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b0, float_src(0, 0, 0, 10'd127, 25'h0800002, 2'b10),
            '0, '0, 4'd1, 32'h3f80_0002, 8'h20, 1'b0);
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b0, float_src(0, 0, 0, 10'd127, 25'h0800002, 2'b11),
            '0, '0, 4'd0, 32'h3f80_0003, 8'h20, 1'b0);
    // directed modes, carry renormalizes
    add_row(RM_ZERO, 8'hff, 1'b0, 1'b0, float_src(0, 0, 0, 10'd127, 25'h0ffffff, 2'b11),
            '0, '0, 4'd2, 32'h3fff_ffff, 8'h20, 1'b0);
    add_row(RM_UP, 8'hff, 1'b0, 1'b0, float_src(0, 0, 0, 10'd127, 25'h0ffffff, 2'b01),
            '0, '0, 4'd0, 32'h4000_0000, 8'h20, 1'b0);
    add_row(RM_UP, 8'hff, 1'b0, 1'b0, float_src(1, 0, 0, 10'd127, 25'h0800000, 2'b11),
            '0, '0, 4'd1, 32'hbf80_0000, 8'h20, 1'b0);
    add_row(RM_DOWN, 8'hff, 1'b0, 1'b0, float_src(1, 0, 0, 10'd127, 25'h0800000, 2'b01),
            '0, '0, 4'd3, 32'hbf80_0001, 8'h20, 1'b0);
    // right shift picks exp_shr
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b0, float_src(0, 0, 1, 10'd128, 25'h1800000, 2'b00),
            '0, '0, 4'd0, 32'h4040_0000, 8'h00, 1'b0);
    // overflow, denormal, zero
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b0, float_src(1, 0, 0, 10'd255, 25'h0800000, 2'b00),
            '0, '0, 4'd2, 32'hff80_0000, 8'ha1, 1'b0);
    add_row(RM_ZERO, 8'hff, 1'b0, 1'b0, float_src(0, 0, 0, 10'd0, 25'h0000010, 2'b10),
            '0, '0, 4'd0, 32'h0000_0010, 8'h22, 1'b0);
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b0, float_src(0, 0, 0, 10'd0, 25'h0, 2'b00),
            '0, '0, 4'd1, 32'h0000_0000, 8'h10, 1'b0);
    // sub zero sign follows the mode
    add_row(RM_DOWN, 8'hff, 1'b0, 1'b0, float_src(0, 1, 0, 10'd0, 25'h0, 2'b00),
            '0, '0, 4'd0, 32'h8000_0000, 8'h10, 1'b0);
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b0, float_src(1, 1, 0, 10'd0, 25'h0, 2'b00),
            '0, '0, 4'd2, 32'h0000_0000, 8'h10, 1'b0);
    // specials: qnan with anan_sign, invalid
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b0, float_src(0, 0, 0, 10'd127, 25'h0800000, 2'b00),
            '0, 5'b00011, 4'd0, 32'hffc0_0000, 8'h08, 1'b0);
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b0, float_src(0, 0, 0, 10'd127, 25'h0800000, 2'b00),
            '0, 5'b10000, 4'd1, 32'h7fbf_ffff, 8'h44, 1'b0);
    // f2i: negate, left shift, right shift with rounding, saturation
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b1, '0, int_src(1, 24'd5, 6'd0, 4'd0, 0),
            '0, 4'd0, 32'hffff_fffb, 8'h00, 1'b0);
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b1, '0, int_src(0, 24'h123, 6'd0, 4'd4, 0),
            '0, 4'd2, 32'h0000_1230, 8'h00, 1'b0);
    add_row(RM_NEAREST, 8'hff, 1'b0, 1'b1, '0, int_src(0, 24'd7, 6'd2, 4'd0, 0),
            '0, 4'd0, 32'h0000_0002, 8'h20, 1'b0);
    add_row(RM_ZERO, 8'hff, 1'b0, 1'b1, '0, int_src(0, 24'd0, 6'd0, 4'd0, 1),
            '0, 4'd1, 32'h7fff_ffff, 8'h40, 1'b0);
    add_row(RM_ZERO, 8'hff, 1'b0, 1'b1, '0, int_src(1, 24'd0, 6'd0, 4'd0, 1),
            '0, 4'd0, 32'h8000_0000, 8'h40, 1'b0);
    // mask and exception enable, long held write-back
    add_row(RM_NEAREST, 8'hdf, 1'b1, 1'b0, float_src(0, 0, 0, 10'd127, 25'h0800001, 2'b10),
            '0, '0, 4'd5, 32'h3f80_0002, 8'h00, 1'b0);
    add_row(RM_NEAREST, 8'hff, 1'b1, 1'b0, float_src(0, 0, 0, 10'd127, 25'h0800001, 2'b10),
            '0, '0, 4'd4, 32'h3f80_0002, 8'h20, 1'b1);
    add_row(RM_NEAREST, 8'h7f, 1'b1, 1'b0, float_src(1, 0, 0, 10'd255, 25'h0800000, 2'b00),
            '0, '0, 4'd5, 32'hff80_0000, 8'h21, 1'b1);
  endtask

  ////////////////////////////////////////
  // per row sequence
  ////////////////////////////////////////

  task automatic run_row(input int idx);
    row_t row;
    int   stall;
    int   since;
    bit   ok;
    row   = rows[idx];
    ok    = 1'b1;
    stall = int'(row.stall) + int'($urandom % 3);
    @(posedge cpu_clk);
    cfg_we_i     <= 1'b1;
    cfg_mode_i   <= row.mode;
    cfg_mask_i   <= row.mask;
    cfg_exc_en_i <= row.exc_en;
    @(posedge cpu_clk);
    cfg_we_i  <= 1'b0;
    fp_rdy_i  <= ~row.use_f2i;
    f2i_rdy_i <= row.use_f2i;
    fp_src_i  <= row.fp;
    f2i_src_i <= row.f2i;
    spec_i    <= row.spec;
    // hold the request until taken
    @(negedge cpu_clk);
    while (!(fp_taking_o || f2i_taking_o)) @(negedge cpu_clk);
    // only the requesting producer is taken
    if (fp_taking_o !== ~row.use_f2i) begin
      $display("FAILED at %0t: fp_taking_o got %b, expected %b",
               $time, fp_taking_o, ~row.use_f2i);
      ok = 1'b0;
    end
    if (f2i_taking_o !== row.use_f2i) begin
      $display("FAILED at %0t: f2i_taking_o got %b, expected %b",
               $time, f2i_taking_o, row.use_f2i);
      ok = 1'b0;
    end
    @(posedge cpu_clk);
    fp_rdy_i  <= 1'b0;
    f2i_rdy_i <= 1'b0;
    // stage 2 loads on the second edge after the take
    since = 0;
    do begin
      @(negedge cpu_clk);
      since++;
    end while (!(valid_o && since >= 3));
    repeat (stall) @(posedge cpu_clk);
    @(posedge cpu_clk);
    padv_wb_i  <= 1'b1;
    grant_wb_i <= 1'b1;
    // exc_o follows the grant within the cycle
    @(negedge cpu_clk);
    if (exc_o !== row.exp_exc) begin
      $display("FAILED at %0t: exc_o got %b, expected %b", $time, exc_o, row.exp_exc);
      ok = 1'b0;
    end
    @(posedge cpu_clk);
    padv_wb_i  <= 1'b0;
    grant_wb_i <= 1'b0;
    @(negedge cpu_clk);
    while (!wb_fpcsr_we_o) @(negedge cpu_clk);
    if (wb_res_o !== row.exp_res) begin
      $display("FAILED at %0t: wb_res_o got %h, expected %h", $time, wb_res_o, row.exp_res);
      ok = 1'b0;
    end
    if (wb_flags_o !== row.exp_flags) begin
      $display("FAILED at %0t: wb_flags_o got %h, expected %h",
               $time, wb_flags_o, row.exp_flags);
      ok = 1'b0;
    end
    if (wb_except_o !== row.exp_exc) begin
      $display("FAILED at %0t: wb_except_o got %b, expected %b",
               $time, wb_except_o, row.exp_exc);
      ok = 1'b0;
    end
    if (ok) pass_cnt++;
    else fail_cnt++;
    $display("row %0d (stall %0d): %s", idx, stall, ok ? "ok" : "mismatch");
  endtask

  // operation killed in stage 0 never reaches write-back
  task automatic flush_check;
    int i;
    bit ok;
    ok = 1'b1;
    @(posedge cpu_clk);
    fp_rdy_i <= 1'b1;
    fp_src_i <= float_src(0, 0, 0, 10'd127, 25'h0800000, 2'b00);
    spec_i   <= '0;
    @(negedge cpu_clk);
    while (!fp_taking_o) @(negedge cpu_clk);
    @(posedge cpu_clk);
    fp_rdy_i   <= 1'b0;
    flush_i    <= 1'b1;
    // flush wins over a write-back grant in the same cycle
    padv_wb_i  <= 1'b1;
    grant_wb_i <= 1'b1;
    @(posedge cpu_clk);
    flush_i    <= 1'b0;
    padv_wb_i  <= 1'b0;
    grant_wb_i <= 1'b0;
    for (i = 0; i < 6; i++) begin
      @(negedge cpu_clk);
      if (valid_o !== 1'b0) begin
        $display("FAILED at %0t: valid_o got %b, expected 0", $time, valid_o);
        ok = 1'b0;
      end
      if (wb_fpcsr_we_o !== 1'b0) begin
        $display("FAILED at %0t: wb_fpcsr_we_o got %b, expected 0", $time, wb_fpcsr_we_o);
        ok = 1'b0;
      end
      if (wb_except_o !== 1'b0) begin
        $display("FAILED at %0t: wb_except_o got %b, expected 0", $time, wb_except_o);
        ok = 1'b0;
      end
    end
    if (ok) pass_cnt++;
    else fail_cnt++;
    $display("flush: %s", ok ? "ok" : "mismatch");
  endtask

  // run length guard
  always @(posedge cpu_clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int max_stall;
    void'($urandom(32'h8af3));
    flush_i      = 1'b0;
    fp_rdy_i     = 1'b0;
    f2i_rdy_i    = 1'b0;
    fp_src_i     = '0;
    f2i_src_i    = '0;
    spec_i       = '0;
    cfg_we_i     = 1'b0;
    cfg_mode_i   = RM_NEAREST;
    cfg_mask_i   = '1;
    cfg_exc_en_i = 1'b0;
    padv_wb_i    = 1'b0;
    grant_wb_i   = 1'b0;
    build_table();
    max_stall = 0;
    foreach (rows[i]) begin
      if (int'(rows[i].stall) > max_stall) max_stall = int'(rows[i].stall);
    end
    // random part adds up to 2
    limit = rows.size() * (12 + max_stall + 2);
    @(posedge arst_n_i);
    foreach (rows[i]) run_row(i);
    flush_check();
    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
design/rnd_fmt_pkg.sv
design/rnd_pipe_pkg.sv
design/rnd_cfg_regs.sv
design/rnd_pipe_ctrl.sv
design/rnd_src_mux.sv
design/rnd_align.sv
design/rnd_round_format.sv
design/rnd_wb_buffer.sv
design/rnd_top.sv
verif/tb_clk_gen.sv
verif/rnd_sva.sv
verif/tb_top.sv
